// ==== hw/mem_access_pkg.sv ====
package mem_access_pkg;

	// Node index split into page and slot
	typedef logic [19:0] page_t;
	typedef logic [8:0]  slot_t;

	typedef logic [1:0]  channel_t;    // Requester channel
	typedef logic [11:0] var_t;
	typedef logic [13:0] frame_t;      // 4 KB memory frame
	typedef logic [25:0] mem_addr_t;   // Byte address
	typedef logic [15:0] mem_word_t;
	typedef logic [95:0] node_data_t;

	typedef enum logic
	{
		fetch_node = 1'b0,
		get_var    = 1'b1
	} req_kind_t;

	typedef struct packed
	{
		req_kind_t kind;
		channel_t  channel;
		page_t     page;
		slot_t     slot;
	} node_req_t;

	typedef struct packed
	{
		channel_t   channel;
		node_data_t data;
	} node_result_t;

	// Low page bits pick the table slot, the rest is the tag
	localparam int PAGE_SLOT_BITS = 8;
	typedef logic [$bits(page_t)-PAGE_SLOT_BITS-1:0] page_tag_t;

	localparam int NODE_BEATS = 6;
	localparam int NODE_BYTES = 12;
	localparam int FRAME_SHIFT = 12;
	localparam int MAX_OUTSTANDING = 4;   // Nodes in flight plus queued results

	typedef logic [2:0] beat_count_t;

endpackage

// ==== hw/host_regs_pkg.sv ====
package host_regs_pkg;

	import mem_access_pkg::*;

	typedef logic        reg_addr_t;
	typedef logic [31:0] reg_data_t;

	localparam reg_addr_t REG_PAGE_SELECT = 1'b0;   // Write page, read slot tag
	localparam reg_addr_t REG_PAGE_INFO = 1'b1;     // Write info and commit, read pending request

	// Lives in the low 28 bits of a REG_PAGE_INFO write
	typedef struct packed
	{
		frame_t frame;
		var_t   variable;
		logic   frame_valid;
		logic   var_valid;
	} page_info_t;

	typedef struct packed
	{
		page_tag_t  tag;
		page_info_t info;
	} page_entry_t;

endpackage

// ==== hw/page_table.sv ====
`timescale 1ns/10ps

module page_table import mem_access_pkg::*, host_regs_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [PAGE_SLOT_BITS-1:0] lookup_slot,
	output page_entry_t               lookup_entry,
	input  logic [PAGE_SLOT_BITS-1:0] host_slot,
	input  page_entry_t               host_entry,
	input  logic                      host_we,
	output page_tag_t                 host_tag
);
	localparam int SLOTS = 2 ** PAGE_SLOT_BITS;

	page_entry_t      entry_mem [SLOTS];
	logic [SLOTS-1:0] slot_valid;   // Slot written since reset
	page_entry_t      lookup_q;
	logic             lookup_valid_q;
	page_tag_t        host_tag_q;
	logic             host_valid_q;

	always_ff @(posedge clk)
	begin
		if (host_we)
			entry_mem[host_slot] <= host_entry;
		lookup_q <= entry_mem[lookup_slot];
		host_tag_q <= entry_mem[host_slot].tag;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			slot_valid <= '0;
			lookup_valid_q <= 1'b0;
			host_valid_q <= 1'b0;
		end
		else
		begin
			if (host_we)
				slot_valid[host_slot] <= 1'b1;
			lookup_valid_q <= slot_valid[lookup_slot];
			host_valid_q <= slot_valid[host_slot];
		end
	end

	// Unwritten slots report both valid bits clear
	always_comb
	begin
		lookup_entry = lookup_q;
		lookup_entry.info.frame_valid = lookup_q.info.frame_valid && lookup_valid_q;
		lookup_entry.info.var_valid = lookup_q.info.var_valid && lookup_valid_q;
	end

	assign host_tag = host_valid_q ? host_tag_q : '0;

	a_no_write_in_reset: assert property (@(posedge clk) reset |-> !host_we);

endmodule

// ==== hw/host_port.sv ====
`timescale 1ns/10ps

module host_port import mem_access_pkg::*, host_regs_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  reg_addr_t                 host_addr,
	input  logic                      host_write,
	input  reg_data_t                 host_writedata,
	input  logic                      host_read,
	output reg_data_t                 host_readdata,
	output logic                      host_readdatavalid,
	input  page_t                     miss_page,
	input  logic                      miss_set,
	output logic                      irq,
	output logic [PAGE_SLOT_BITS-1:0] table_slot,
	output page_entry_t               table_entry,
	output logic                      table_we,
	output logic                      commit,
	input  page_tag_t                 table_tag
);
	page_t     select_q;    // Page chosen by REG_PAGE_SELECT
	reg_data_t pending_q;   // Missing page above the pending flag
	reg_addr_t read_addr_q;
	logic      info_write;

	assign info_write = host_write && host_addr == REG_PAGE_INFO;

	assign table_slot = select_q[PAGE_SLOT_BITS-1:0];
	assign table_entry = '{
		tag:  select_q[$bits(page_t)-1:PAGE_SLOT_BITS],
		info: page_info_t'(host_writedata[$bits(page_info_t)-1:0])
	};
	assign table_we = info_write;
	assign commit = info_write;   // Info write also acknowledges the miss
	assign irq = pending_q[0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			select_q <= '0;
			pending_q <= '0;
			read_addr_q <= REG_PAGE_SELECT;
			host_readdatavalid <= 1'b0;
		end
		else
		begin
			if (host_write && host_addr == REG_PAGE_SELECT)
				select_q <= host_writedata[$bits(page_t)-1:0];
			if (miss_set)
				pending_q <= reg_data_t'({miss_page, 1'b1});
			else if (commit)
				pending_q[0] <= 1'b0;
			read_addr_q <= host_addr;
			host_readdatavalid <= host_read;   // Fixed one cycle read latency
		end
	end

	// Tag comes from the table's registered host port
	assign host_readdata = (read_addr_q == REG_PAGE_SELECT) ? reg_data_t'(table_tag) : pending_q;

	// A new miss must not overwrite one that is still pending
	a_one_miss_pending: assert property (@(posedge clk) disable iff (reset)
		miss_set |-> !irq);

endmodule

// ==== hw/lookup_ctrl.sv ====
`timescale 1ns/10ps

module lookup_ctrl import mem_access_pkg::*, host_regs_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  node_req_t                 req,
	input  logic                      req_valid,
	output logic                      req_ready,
	output logic [PAGE_SLOT_BITS-1:0] lookup_slot,
	input  page_entry_t               lookup_entry,
	output page_t                     miss_page,
	output logic                      miss_set,
	input  logic                      commit,
	output mem_addr_t                 cmd_addr,
	output channel_t                  cmd_channel,
	output logic                      cmd_valid,
	input  logic                      cmd_ready,
	output var_t                      var_out,
	output logic                      var_valid,
	input  logic                      var_ready
);
	typedef enum logic [2:0]
	{
		idle,
		read,
		compare,
		miss_wait,
		issue,
		return_var
	} state_t;

	state_t    state;
	node_req_t req_q;
	var_t      var_q;
	mem_addr_t cmd_addr_q;
	logic      tag_match;
	logic      kind_valid;
	logic      hit;
	mem_addr_t node_addr;

	assign req_ready = state == idle;
	assign lookup_slot = req_q.page[PAGE_SLOT_BITS-1:0];

	assign tag_match = lookup_entry.tag == req_q.page[$bits(page_t)-1:PAGE_SLOT_BITS];
	// Each kind needs its own valid bit
	assign kind_valid = (req_q.kind == fetch_node) ? lookup_entry.info.frame_valid
	                                               : lookup_entry.info.var_valid;
	assign hit = tag_match && kind_valid;

	assign node_addr = (mem_addr_t'(lookup_entry.info.frame) << FRAME_SHIFT)
	                 + mem_addr_t'(req_q.slot) * mem_addr_t'(NODE_BYTES);

	assign miss_page = req_q.page;
	assign miss_set = state == compare && !hit;

	assign cmd_addr = cmd_addr_q;
	assign cmd_channel = req_q.channel;
	assign cmd_valid = state == issue;

	// Variable goes out straight from the table on the compare cycle
	assign var_valid = (state == compare && hit && req_q.kind == get_var) || state == return_var;
	assign var_out = (state == return_var) ? var_q : lookup_entry.info.variable;

	always_ff @(posedge clk)
	begin
		if (state == idle && req_valid)
			req_q <= req;
		if (state == compare)
		begin
			var_q <= lookup_entry.info.variable;
			cmd_addr_q <= node_addr;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= idle;
		else
		begin
			case (state)
				idle: if (req_valid) state <= read;
				read: state <= compare;   // Table read in flight
				compare:
				begin
					if (!hit)
						state <= miss_wait;
					else if (req_q.kind == fetch_node)
						state <= issue;
					else if (var_ready)
						state <= idle;
					else
						state <= return_var;
				end
				miss_wait: if (commit) state <= read;   // Look up again
				issue: if (cmd_ready) state <= idle;
				return_var: if (var_ready) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// A command stays unchanged until node_reader takes it
	a_cmd_held: assert property (@(posedge clk) disable iff (reset)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_addr) && $stable(cmd_channel));

endmodule

// ==== hw/node_reader.sv ====
`timescale 1ns/10ps

module node_reader import mem_access_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  mem_addr_t   cmd_addr,
	input  channel_t    cmd_channel,
	input  logic        cmd_valid,
	output logic        cmd_ready,
	input  logic        credit_ok,
	output mem_addr_t   mem_address,
	output logic        mem_read,
	output beat_count_t mem_burstcount,
	input  logic        mem_waitrequest,
	output logic        issued,
	output channel_t    issued_channel
);
	logic      busy_q;   // Burst waiting on the bus
	mem_addr_t addr_q;
	channel_t  chan_q;

	assign cmd_ready = !busy_q && credit_ok;

	always_ff @(posedge clk)
	begin
		if (cmd_valid && cmd_ready)
		begin
			addr_q <= cmd_addr;
			chan_q <= cmd_channel;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			busy_q <= 1'b0;
		else if (cmd_valid && cmd_ready)
			busy_q <= 1'b1;
		else if (issued)
			busy_q <= 1'b0;
	end

	assign mem_read = busy_q;
	assign mem_address = addr_q;
	assign mem_burstcount = beat_count_t'(NODE_BEATS);

	assign issued = busy_q && !mem_waitrequest;   // Read accepted by memory
	assign issued_channel = chan_q;

	a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
		mem_read && mem_waitrequest |=> mem_read && $stable(mem_address)
		&& $stable(mem_burstcount));

endmodule

// ==== hw/response_collector.sv ====
`timescale 1ns/10ps

module response_collector import mem_access_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         issued,
	input  channel_t     issued_channel,
	input  mem_word_t    mem_readdata,
	input  logic         mem_readdatavalid,
	output logic         credit_ok,
	output node_result_t result,
	output logic         result_valid,
	input  logic         result_ready
);
	localparam int PTR_BITS = $clog2(MAX_OUTSTANDING);

	channel_t            chan_fifo [MAX_OUTSTANDING];   // Channels of bursts in flight
	logic [PTR_BITS-1:0] chan_wr;
	logic [PTR_BITS-1:0] chan_rd;
	logic [PTR_BITS:0]   chan_count;
	node_result_t        res_fifo [MAX_OUTSTANDING];
	logic [PTR_BITS-1:0] res_wr;
	logic [PTR_BITS-1:0] res_rd;
	logic [PTR_BITS:0]   res_count;
	logic [PTR_BITS+1:0] in_use;
	beat_count_t         beat;
	node_data_t          node_buf;
	node_data_t          node_next;
	logic                node_done;
	logic                res_pop;

	// Current beat merged into the partial node, low beat first
	always_comb
	begin
		node_next = node_buf;
		node_next[beat*16 +: 16] = mem_readdata;
	end

	assign node_done = mem_readdatavalid && beat == beat_count_t'(NODE_BEATS - 1);
	assign res_pop = result_valid && result_ready;

	always_ff @(posedge clk)
	begin
		if (issued)
			chan_fifo[chan_wr] <= issued_channel;
		if (node_done)
			res_fifo[res_wr] <= '{channel: chan_fifo[chan_rd], data: node_next};
		if (mem_readdatavalid)
			node_buf <= node_next;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			chan_wr <= '0;
			chan_rd <= '0;
			chan_count <= '0;
			res_wr <= '0;
			res_rd <= '0;
			res_count <= '0;
			beat <= '0;
		end
		else
		begin
			if (issued)
				chan_wr <= chan_wr + 1'b1;
			if (node_done)
			begin
				chan_rd <= chan_rd + 1'b1;
				res_wr <= res_wr + 1'b1;
			end
			if (res_pop)
				res_rd <= res_rd + 1'b1;
			chan_count <= chan_count + {{PTR_BITS{1'b0}}, issued} - {{PTR_BITS{1'b0}}, node_done};
			res_count <= res_count + {{PTR_BITS{1'b0}}, node_done} - {{PTR_BITS{1'b0}}, res_pop};
			if (mem_readdatavalid)
				beat <= node_done ? '0 : beat + 1'b1;
		end
	end

	assign result = res_fifo[res_rd];
	assign result_valid = res_count != '0;

	// A node holds its slot from issue until the result is taken
	assign in_use = {1'b0, chan_count} + {1'b0, res_count};
	assign credit_ok = in_use < (PTR_BITS + 2)'(MAX_OUTSTANDING);

	a_no_stray_beat: assert property (@(posedge clk) disable iff (reset)
		mem_readdatavalid |-> chan_count != '0);

endmodule

// ==== hw/memory_access.sv ====
`timescale 1ns/10ps

module memory_access import mem_access_pkg::*, host_regs_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  node_req_t    req,
	input  logic         req_valid,
	output logic         req_ready,
	input  reg_addr_t    host_addr,
	input  logic         host_write,
	input  reg_data_t    host_writedata,
	input  logic         host_read,
	output reg_data_t    host_readdata,
	output logic         host_readdatavalid,
	output logic         irq,
	output mem_addr_t    mem_address,
	output logic         mem_read,
	output beat_count_t  mem_burstcount,
	input  logic         mem_waitrequest,
	input  mem_word_t    mem_readdata,
	input  logic         mem_readdatavalid,
	output node_result_t result,
	output logic         result_valid,
	input  logic         result_ready,
	output var_t         var_out,
	output logic         var_valid,
	input  logic         var_ready
);
	logic [PAGE_SLOT_BITS-1:0] lookup_slot;
	page_entry_t               lookup_entry;
	logic [PAGE_SLOT_BITS-1:0] table_slot;
	page_entry_t               table_entry;
	logic                      table_we;
	page_tag_t                 table_tag;
	logic                      commit;
	page_t                     miss_page;
	logic                      miss_set;
	mem_addr_t                 cmd_addr;
	channel_t                  cmd_channel;
	logic                      cmd_valid;
	logic                      cmd_ready;
	logic                      credit_ok;
	logic                      issued;
	channel_t                  issued_channel;

	page_table u_page_table (
		.clk, .reset,
		.lookup_slot, .lookup_entry,
		.host_slot(table_slot), .host_entry(table_entry), .host_we(table_we),
		.host_tag(table_tag)
	);

	host_port u_host_port (
		.clk, .reset,
		.host_addr, .host_write, .host_writedata, .host_read,
		.host_readdata, .host_readdatavalid,
		.miss_page, .miss_set, .irq,
		.table_slot, .table_entry, .table_we, .commit, .table_tag
	);

	lookup_ctrl u_lookup_ctrl (
		.clk, .reset,
		.req, .req_valid, .req_ready,
		.lookup_slot, .lookup_entry,
		.miss_page, .miss_set, .commit,
		.cmd_addr, .cmd_channel, .cmd_valid, .cmd_ready,
		.var_out, .var_valid, .var_ready
	);

	node_reader u_node_reader (
		.clk, .reset,
		.cmd_addr, .cmd_channel, .cmd_valid, .cmd_ready, .credit_ok,
		.mem_address, .mem_read, .mem_burstcount, .mem_waitrequest,
		.issued, .issued_channel
	);

	response_collector u_response_collector (
		.clk, .reset,
		.issued, .issued_channel,
		.mem_readdata, .mem_readdatavalid,
		.credit_ok,
		.result, .result_valid, .result_ready
	);

endmodule

// ==== tb/mem_access_checker.sv ====
`timescale 1ns/10ps

module mem_access_checker import mem_access_pkg::*, host_regs_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         done,
	input  node_req_t    req,
	input  logic         req_valid,
	input  logic         req_ready,
	input  mem_addr_t    exp_addr,
	input  var_t         exp_var,
	input  logic         exp_miss,
	input  logic         irq,
	input  reg_addr_t    host_addr,
	input  logic         host_write,
	input  logic         host_read,
	input  reg_data_t    host_readdata,
	input  logic         host_readdatavalid,
	input  mem_addr_t    mem_address,
	input  logic         mem_read,
	input  beat_count_t  mem_burstcount,
	input  logic         mem_waitrequest,
	input  node_result_t result,
	input  logic         result_valid,
	input  logic         result_ready,
	input  var_t         var_out,
	input  logic         var_valid,
	input  logic         var_ready,
	output int           error_count,
	output int           pending
);
	mem_addr_t  cmd_q [$];   // Fetch addresses not yet seen on the bus
	mem_addr_t  res_q [$];
	channel_t   chan_q [$];
	var_t       var_q [$];
	page_t      cur_page;
	logic       cur_miss;
	logic       irq_seen;
	logic       have_req = 1'b0;
	logic       reset_d = 1'b0;
	logic       info_write_d = 1'b0;
	reg_addr_t  read_addr_d;
	int         errors = 0;
	mem_addr_t  base;
	node_data_t exp_data;

	assign error_count = errors;

	task automatic mismatch(input string name, input logic [95:0] got,
		input logic [95:0] want);
		$display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, want);
		errors++;
	endtask

	task automatic unexpected(input string what);
		$display("Error at %0d ns: %s", $time, what);
		errors++;
	endtask

	// irq must have risen during the request exactly when a miss was expected
	task automatic close_request();
		if (have_req && irq_seen != cur_miss)
			mismatch("irq", irq_seen, cur_miss);
		have_req = 1'b0;
	endtask

	always @(posedge clk)
	begin
		reset_d <= reset;
		if (reset_d)
		begin
			if (irq || result_valid || var_valid || mem_read || host_readdatavalid)
				unexpected("an output is active right after reset");
			if (!req_ready)
				mismatch("req_ready", req_ready, 1'b1);
		end
		if (!reset)
		begin
			if (info_write_d && irq)
				mismatch("irq", irq, 1'b0);   // Should drop after the info write
			if (host_readdatavalid && read_addr_d == REG_PAGE_INFO
				&& host_readdata != {11'd0, cur_page, 1'b1})
				mismatch("host_readdata", host_readdata, {11'd0, cur_page, 1'b1});
			if (req_valid && req_ready)
			begin
				close_request();
				cur_page = req.page;
				cur_miss = exp_miss;
				irq_seen = 1'b0;
				have_req = 1'b1;
				if (req.kind == fetch_node)
				begin
					cmd_q.push_back(exp_addr);
					res_q.push_back(exp_addr);
					chan_q.push_back(req.channel);
				end
				else
					var_q.push_back(exp_var);
			end
			if (irq)
				irq_seen = 1'b1;
			if (mem_read && !mem_waitrequest)
			begin
				if (cmd_q.size() == 0)
					unexpected("memory read issued with no fetch pending");
				else
				begin
					base = cmd_q.pop_front();
					if (mem_address != base)
						mismatch("mem_address", mem_address, base);
					if (mem_burstcount != 3'd6)
						mismatch("mem_burstcount", mem_burstcount, 3'd6);
				end
			end
			if (result_valid && result_ready)
			begin
				if (res_q.size() == 0)
					unexpected("result returned with no fetch outstanding");
				else
				begin
					base = res_q.pop_front();
					for (int k = 0; k < NODE_BEATS; k++)
						exp_data[k*16 +: 16] = mem_word_t'(base + mem_addr_t'(k));
					if (result.channel != chan_q[0])
						mismatch("result.channel", result.channel, chan_q[0]);
					if (result.data != exp_data)
						mismatch("result.data", result.data, exp_data);
					void'(chan_q.pop_front());
				end
			end
			if (var_valid && var_ready)
			begin
				if (var_q.size() == 0)
					unexpected("variable returned with no get_var outstanding");
				else if (var_out != var_q[0])
					mismatch("var_out", var_out, var_q[0]);
				if (var_q.size() != 0)
					void'(var_q.pop_front());
			end
			if (done)
				close_request();
		end
		info_write_d <= host_write && host_addr == REG_PAGE_INFO;
		if (host_read)
			read_addr_d <= host_addr;
		pending = res_q.size() + var_q.size();
	end

endmodule

// ==== tb/tb_memory_access.sv ====
`timescale 1ns/10ps

module tb_memory_access import mem_access_pkg::*, host_regs_pkg::*; ();
	localparam int CASE_FIELDS = 9;   // Words per line of the case file
	localparam int MAX_CASES = 32;
	localparam int WAIT_LIMIT = 2000;

	logic         clk;
	logic         reset;
	node_req_t    req;
	logic         req_valid;
	logic         req_ready;
	reg_addr_t    host_addr = REG_PAGE_SELECT;
	logic         host_write = 1'b0;
	reg_data_t    host_writedata = '0;
	logic         host_read = 1'b0;
	reg_data_t    host_readdata;
	logic         host_readdatavalid;
	logic         irq;
	mem_addr_t    mem_address;
	logic         mem_read;
	beat_count_t  mem_burstcount;
	logic         mem_waitrequest = 1'b0;
	mem_word_t    mem_readdata = '0;
	logic         mem_readdatavalid = 1'b0;
	node_result_t result;
	logic         result_valid;
	logic         result_ready = 1'b0;
	var_t         var_out;
	logic         var_valid;
	logic         var_ready = 1'b0;

	mem_addr_t    exp_addr;
	var_t         exp_var;
	logic         exp_miss;
	logic         done;
	int           error_count;
	int           pending;
	int           timeouts = 0;
	integer       seed = 35;
	reg_data_t    cur_info;      // Page info the host writes on a miss
	logic [19:0]  case_mem [CASE_FIELDS*MAX_CASES];
	mem_addr_t    burst_q [$];   // Accepted bursts still returning beats
	int           beat_k = 0;

	memory_access u_dut (.*);
	mem_access_checker u_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (!reset && mem_read && !mem_waitrequest)
			burst_q.push_back(mem_address);
	end

	// Random stalls on both sides, beats come back in order
	always @(negedge clk)
	begin
		mem_waitrequest = ($random(seed) & 3) == 0;
		result_ready = ($random(seed) & 3) != 0;
		var_ready = ($random(seed) & 3) != 0;
		mem_readdatavalid = 1'b0;
		mem_readdata = '0;
		if (burst_q.size() != 0 && ($random(seed) & 7) != 0)
		begin
			mem_readdata = mem_word_t'(burst_q[0] + mem_addr_t'(beat_k));
			mem_readdatavalid = 1'b1;
			beat_k++;
			if (beat_k == NODE_BEATS)
			begin
				beat_k = 0;
				void'(burst_q.pop_front());
			end
		end
	end

	task automatic serve_miss();
		page_t page;
		int    waited;
		host_addr = REG_PAGE_INFO;
		host_read = 1'b1;
		@(negedge clk);
		host_read = 1'b0;
		waited = 0;
		while (!host_readdatavalid && waited < 4)
		begin
			@(negedge clk);
			waited++;
		end
		if (!host_readdatavalid)
		begin
			$display("Timed out waiting for host read data at %0d ns", $time);
			timeouts++;
		end
		page = host_readdata[20:1];   // Pending page sits above the flag
		host_addr = REG_PAGE_SELECT;
		host_write = 1'b1;
		host_writedata = reg_data_t'(page);
		@(negedge clk);
		host_addr = REG_PAGE_INFO;
		host_writedata = cur_info;
		@(negedge clk);
		host_write = 1'b0;
	endtask

	initial
	begin
		forever
		begin
			@(negedge clk);
			if (!reset && irq)
				serve_miss();
		end
	end

	task automatic load_case(input int n);
		int     b;
		frame_t frame;
		var_t   variable;
		b = n * CASE_FIELDS;
		frame = frame_t'(case_mem[b + 4]);
		variable = var_t'(case_mem[b + 5]);
		req.kind = req_kind_t'(case_mem[b][0]);
		req.channel = channel_t'(case_mem[b + 1]);
		req.page = case_mem[b + 2];
		req.slot = slot_t'(case_mem[b + 3]);
		// 4 KB frames holding 12-byte nodes
		exp_addr = mem_addr_t'(frame) * 26'd4096 + mem_addr_t'(req.slot) * 26'd12;
		exp_var = variable;
		exp_miss = case_mem[b + 8][0];
		cur_info = {4'd0, frame, variable, case_mem[b + 6][0], case_mem[b + 7][0]};
	endtask

	task automatic send_request(input int n, output logic ok);
		int waited;
		waited = 0;
		while (!req_ready && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		ok = req_ready;
		if (!ok)
		begin
			$display("Timed out waiting for req_ready before case %0d", n);
			timeouts++;
		end
		else
		begin
			load_case(n);
			req_valid = 1'b1;
			@(negedge clk);   // Taken on the rising edge in between
			req_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while ((pending != 0 || !req_ready) && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (pending != 0 || !req_ready)
		begin
			$display("Timed out with %0d responses still outstanding", pending);
			timeouts++;
		end
	endtask

	initial
	begin
		int   n;
		logic ok;
		reset = 1'b1;
		req = '0;
		req_valid = 1'b0;
		exp_addr = '0;
		exp_var = '0;
		exp_miss = 1'b0;
		done = 1'b0;
		cur_info = '0;
		$readmemh("tb/mem_access_cases.txt", case_mem);
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		n = 0;
		ok = 1'b1;
		while (ok && n < MAX_CASES && case_mem[n * CASE_FIELDS] != 20'hf)   // Kind f ends the list
		begin
			send_request(n, ok);
			n++;
		end
		if (ok)
			drain();
		@(negedge clk);
		done = 1'b1;
		@(negedge clk);
		done = 1'b0;
		$display("Ran %0d requests with %0d errors and %0d timeouts", n, error_count, timeouts);
		if (error_count == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== tb/mem_access_cases.txt ====
// kind channel page slot frame variable frame_valid var_valid miss, all hex
// kind 0 fetches a node, 1 reads the variable, f ends the list; miss 1 expects irq
0 1 00012 005 0123 0a1 1 1 1
0 2 00012 010 0123 0a1 1 1 0
1 3 00012 000 0123 0a1 1 1 0
0 0 00345 1ff 0044 3c5 1 0 1
1 1 00345 002 0044 3c5 1 1 1
0 3 00345 020 0044 3c5 1 1 0
0 2 01012 004 3f80 7ff 1 1 1
0 1 00012 006 0123 0a1 1 1 1
0 0 00012 007 0123 0a1 1 1 0
0 3 00012 1a0 0123 0a1 1 1 0
0 2 00345 0c3 0044 3c5 1 1 0
1 0 00345 000 0044 3c5 1 1 0
f 0 00000 000 0000 000 0 0 0

// ==== build.f ====
hw/mem_access_pkg.sv
hw/host_regs_pkg.sv
hw/page_table.sv
hw/host_port.sv
hw/lookup_ctrl.sv
hw/node_reader.sv
hw/response_collector.sv
hw/memory_access.sv
tb/mem_access_checker.sv
tb/tb_memory_access.sv

// ==== Makefile ====
TOP = tb_memory_access

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f -o sim
	./obj_dir/sim | awk '{ print } /^No errors$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module memory_access -f build.f

clean:
	rm -rf obj_dir
